// File: dispatch_pkg.sv
package dispatch_pkg;

  localparam int INSN_BITS    = 32;
  localparam int GPR_IDX_BITS = 5;
  localparam int IMM_BITS     = 64;
  localparam int LINK_REG     = 30;

  // One value per supported instruction, plus the error class.
  typedef enum logic [5:0] {
    OP_LDUR, OP_STUR, OP_LDP, OP_STP,
    OP_MOVK, OP_MOVZ, OP_ADR, OP_ADRP,
    OP_ADD, OP_ADDS, OP_SUB, OP_SUBS,
    OP_AND, OP_ANDS, OP_ORR, OP_ORN, OP_EOR,
    OP_UBFM, OP_SBFM,
    OP_CSEL, OP_CSINC, OP_CSINV, OP_CSNEG,
    OP_B, OP_B_COND, OP_BL, OP_BLR, OP_BR, OP_RET, OP_CBZ, OP_CBNZ,
    OP_NOP, OP_HLT,
    OP_ERR
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_OP_PLUS, ALU_OP_MINUS, ALU_OP_AND, ALU_OP_OR, ALU_OP_ORN, ALU_OP_EOR,
    ALU_OP_UBFM, ALU_OP_SBFM, ALU_OP_MOV,
    ALU_OP_CSEL, ALU_OP_CSINC, ALU_OP_CSINV, ALU_OP_CSNEG
  } alu_op_t;

  typedef enum logic {
    FU_ALU,
    FU_LS
  } fu_t;

  // AArch64 condition codes in encoding order.
  typedef enum logic [3:0] {
    COND_EQ, COND_NE, COND_CS, COND_CC, COND_MI, COND_PL, COND_VS, COND_VC,
    COND_HI, COND_LS, COND_GE, COND_LT, COND_GT, COND_LE, COND_AL, COND_NV
  } cond_t;

  // Register-format view of the instruction word.
  typedef struct packed {
    logic [10:0]             opc_hi;
    logic [GPR_IDX_BITS-1:0] rm;
    logic [3:0]              cond;
    logic [1:0]              op2;
    logic [GPR_IDX_BITS-1:0] rn;
    logic [GPR_IDX_BITS-1:0] rd;
  } insn_reg_t;

  // Immediate-format view. The imm12, imm9 and imm16 fields overlap immhi.
  typedef struct packed {
    logic                    sf;
    logic [1:0]              immlo;
    logic [4:0]              op_mid;
    logic [18:0]             immhi;
    logic [GPR_IDX_BITS-1:0] rd;
  } insn_imm_t;

  typedef union packed {
    insn_reg_t r;
    insn_imm_t i;
  } insn_u;

  // Micro-op bundle handed to the register file and ROB.
  typedef struct packed {
    logic                    illegal;
    logic                    set_nzcv;
    logic                    uses_nzcv;
    logic                    use_imm;
    logic [IMM_BITS-1:0]     imm;
    logic [GPR_IDX_BITS-1:0] src1;
    logic [GPR_IDX_BITS-1:0] src2;
    logic [GPR_IDX_BITS-1:0] dst;
    fu_t                     fu_id;
    alu_op_t                 alu_op;
    cond_t                   cond;
  } dispatch_uop_t;

endpackage

// File: dispatch_ctrl.sv
`timescale 1ns/100ps

module dispatch_ctrl import dispatch_pkg::*; (
  input  logic                 in_clk,
  input  logic                 rst_n,
  input  logic                 in_stall,
  input  logic                 in_fetch_done,
  input  logic [INSN_BITS-1:0] in_fetch_insn,
  output logic                 done,
  output insn_u                insn_q,
  output opcode_t              opcode
);

  // Stall freezes both the done flag and the instruction register.
  always_ff @(posedge in_clk or negedge rst_n) begin
    if (!rst_n) begin
      done   <= 1'b0;
      insn_q <= '0;
    end else if (!in_stall) begin
      done <= in_fetch_done;
      if (in_fetch_done) begin
        insn_q <= in_fetch_insn;
      end
    end
  end

  // Opcode class from the registered word. First match wins.
  always_comb begin
    casez (insn_q)
      // Loads and stores.
      32'b1111_1000_010?_????_????_00??_????_????: opcode = OP_LDUR;
      32'b1111_1000_000?_????_????_00??_????_????: opcode = OP_STUR;
      32'b1010_1000_11??_????_????_????_????_????: opcode = OP_LDP;
      32'b1010_1001_00??_????_????_????_????_????: opcode = OP_STP;
      // Wide moves and PC-relative addresses.
      32'b1111_0010_1???_????_????_????_????_????: opcode = OP_MOVK;
      32'b1101_0010_1???_????_????_????_????_????: opcode = OP_MOVZ;
      32'b0??1_0000_????_????_????_????_????_????: opcode = OP_ADR;
      32'b1??1_0000_????_????_????_????_????_????: opcode = OP_ADRP;
      // Conditional selects, bits 11:10 pick the variant.
      32'b1001_1010_100?_????_????_01??_????_????: opcode = OP_CSINC;
      32'b1101_1010_100?_????_????_00??_????_????: opcode = OP_CSINV;
      32'b1101_1010_100?_????_????_01??_????_????: opcode = OP_CSNEG;
      32'b1001_1010_100?_????_????_00??_????_????: opcode = OP_CSEL;
      // Arithmetic and logic.
      32'b1001_0001_0???_????_????_????_????_????: opcode = OP_ADD;
      32'b1010_1011_000?_????_????_????_????_????: opcode = OP_ADDS;
      32'b1101_0001_0???_????_????_????_????_????: opcode = OP_SUB;
      32'b1110_1011_000?_????_????_????_????_????: opcode = OP_SUBS;
      32'b1010_1010_001?_????_????_????_????_????: opcode = OP_ORN;
      32'b1010_1010_000?_????_????_????_????_????: opcode = OP_ORR;
      32'b1100_1010_000?_????_????_????_????_????: opcode = OP_EOR;
      32'b1001_0010_00??_????_????_????_????_????: opcode = OP_AND;
      32'b1110_1010_000?_????_????_????_????_????: opcode = OP_ANDS;
      // Bitfield moves.
      32'b1101_0011_01??_????_????_????_????_????: opcode = OP_UBFM;
      32'b1001_0011_01??_????_????_????_????_????: opcode = OP_SBFM;
      // Branches.
      32'b0001_01??_????_????_????_????_????_????: opcode = OP_B;
      32'b0101_0100_????_????_????_????_???0_????: opcode = OP_B_COND;
      32'b1001_01??_????_????_????_????_????_????: opcode = OP_BL;
      32'b1101_0110_0011_1111_0000_00??_???0_0000: opcode = OP_BLR;
      32'b1101_0110_0001_1111_0000_00??_???0_0000: opcode = OP_BR;
      32'b1101_0110_0101_1111_0000_00??_???0_0000: opcode = OP_RET;
      32'b1011_0101_????_????_????_????_????_????: opcode = OP_CBNZ;
      32'b1011_0100_????_????_????_????_????_????: opcode = OP_CBZ;
      // System.
      32'b1101_0101_0000_0011_0010_0000_0001_1111: opcode = OP_NOP;
      32'b1101_0100_010?_????_????_????_???0_0000: opcode = OP_HLT;
      default:                                     opcode = OP_ERR;
    endcase
  end

endmodule

// File: imm_extract.sv
`timescale 1ns/100ps

module imm_extract import dispatch_pkg::*; (
  input  insn_u               insn_q,
  input  opcode_t             opcode,
  output logic [IMM_BITS-1:0] imm,
  output logic                use_imm
);

  logic [8:0]  imm9;
  logic [11:0] imm12;
  logic [15:0] imm16;

  // Narrow fields sit inside immhi, which spans word bits 23:5.
  assign imm9  = insn_q.i.immhi[15:7];
  assign imm12 = insn_q.i.immhi[16:5];
  assign imm16 = insn_q.i.immhi[15:0];

  always_comb begin
    case (opcode)
      OP_LDUR, OP_STUR:                 imm = IMM_BITS'(imm9);
      OP_ADD, OP_SUB, OP_UBFM, OP_SBFM: imm = IMM_BITS'(imm12);
      OP_MOVK, OP_MOVZ:                 imm = IMM_BITS'(imm16);
      // Page offset, low twelve bits are zero.
      OP_ADRP: imm = IMM_BITS'({insn_q.i.immhi, insn_q.i.immlo, 12'h000});
      default: imm = '0;
    endcase
  end

  always_comb begin
    case (opcode)
      OP_LDUR, OP_STUR, OP_LDP, OP_STP,
      OP_MOVK, OP_MOVZ, OP_ADR, OP_ADRP,
      OP_ADD, OP_SUB, OP_AND, OP_UBFM, OP_SBFM,
      OP_B, OP_B_COND, OP_BL, OP_BR, OP_BLR: use_imm = 1'b1;
      default:                               use_imm = 1'b0;
    endcase
  end

endmodule

// File: reg_extract.sv
`timescale 1ns/100ps

module reg_extract import dispatch_pkg::*; (
  input  insn_u                   insn_q,
  input  opcode_t                 opcode,
  output logic [GPR_IDX_BITS-1:0] src1,
  output logic [GPR_IDX_BITS-1:0] src2,
  output logic [GPR_IDX_BITS-1:0] dst
);

  // First source. Compare-and-branch tests the register in the rd slot.
  always_comb begin
    case (opcode)
      OP_CBZ, OP_CBNZ: src1 = insn_q.r.rd;
      OP_MOVK, OP_MOVZ, OP_ADR, OP_ADRP,
      OP_B, OP_B_COND, OP_BL,
      OP_NOP, OP_HLT, OP_ERR: src1 = '0;
      default:                src1 = insn_q.r.rn;
    endcase
  end

  // Second source. Store data also comes from the rd slot.
  always_comb begin
    case (opcode)
      OP_STUR: src2 = insn_q.r.rd;
      OP_ADDS, OP_SUBS, OP_ANDS, OP_ORR, OP_ORN, OP_EOR,
      OP_CSEL, OP_CSINC, OP_CSINV, OP_CSNEG: src2 = insn_q.r.rm;
      default:                               src2 = '0;
    endcase
  end

  // Destination. Branch-with-link writes the return address to x30.
  always_comb begin
    case (opcode)
      OP_BL, OP_BLR: dst = GPR_IDX_BITS'(LINK_REG);
      OP_STUR, OP_STP,
      OP_B, OP_B_COND, OP_BR, OP_RET, OP_CBZ, OP_CBNZ,
      OP_NOP, OP_HLT, OP_ERR: dst = '0;
      default:                dst = insn_q.r.rd;
    endcase
  end

endmodule

// File: uop_classify.sv
`timescale 1ns/100ps

module uop_classify import dispatch_pkg::*; (
  input  insn_u   insn_q,
  input  opcode_t opcode,
  output alu_op_t alu_op,
  output fu_t     fu_id,
  output cond_t   cond,
  output logic    set_nzcv,
  output logic    uses_nzcv,
  output logic    illegal
);

  logic is_csel_family;

  assign is_csel_family = (opcode == OP_CSEL) || (opcode == OP_CSINC) ||
                          (opcode == OP_CSINV) || (opcode == OP_CSNEG);

  // Address generation for memory ops also goes through PLUS.
  always_comb begin
    case (opcode)
      OP_SUB, OP_SUBS:  alu_op = ALU_OP_MINUS;
      OP_AND, OP_ANDS:  alu_op = ALU_OP_AND;
      OP_ORR:           alu_op = ALU_OP_OR;
      OP_ORN:           alu_op = ALU_OP_ORN;
      OP_EOR:           alu_op = ALU_OP_EOR;
      OP_UBFM:          alu_op = ALU_OP_UBFM;
      OP_SBFM:          alu_op = ALU_OP_SBFM;
      OP_MOVK, OP_MOVZ: alu_op = ALU_OP_MOV;
      OP_CSEL:          alu_op = ALU_OP_CSEL;
      OP_CSINC:         alu_op = ALU_OP_CSINC;
      OP_CSINV:         alu_op = ALU_OP_CSINV;
      OP_CSNEG:         alu_op = ALU_OP_CSNEG;
      default:          alu_op = ALU_OP_PLUS;
    endcase
  end

  always_comb begin
    case (opcode)
      OP_LDUR, OP_STUR, OP_LDP, OP_STP: fu_id = FU_LS;
      default:                          fu_id = FU_ALU;
    endcase
  end

  // B.cond keeps its condition in bits 3:0, the selects in bits 15:12.
  always_comb begin
    if (opcode == OP_B_COND) begin
      cond = cond_t'(insn_q.r.rd[3:0]);
    end else if (is_csel_family) begin
      cond = cond_t'(insn_q.r.cond);
    end else begin
      cond = COND_EQ;
    end
  end

  assign set_nzcv  = (opcode == OP_ADDS) || (opcode == OP_SUBS) || (opcode == OP_ANDS);
  assign uses_nzcv = (opcode == OP_B_COND) || is_csel_family;
  assign illegal   = (opcode == OP_ERR);

endmodule

// File: dispatch_stage.sv
`timescale 1ns/100ps

module dispatch_stage import dispatch_pkg::*; (
  input  logic                 in_clk,
  input  logic                 rst_n,
  input  logic                 in_stall,
  input  logic                 in_fetch_done,
  input  logic [INSN_BITS-1:0] in_fetch_insn,
  output logic                 done,
  output dispatch_uop_t        uop
);

  insn_u   insn_q;
  opcode_t opcode;

  dispatch_ctrl i_ctrl (
    .in_clk        (in_clk),
    .rst_n         (rst_n),
    .in_stall      (in_stall),
    .in_fetch_done (in_fetch_done),
    .in_fetch_insn (in_fetch_insn),
    .done          (done),
    .insn_q        (insn_q),
    .opcode        (opcode)
  );

  // The datapaths below are purely combinational off the registered word.
  imm_extract i_imm (
    .insn_q  (insn_q),
    .opcode  (opcode),
    .imm     (uop.imm),
    .use_imm (uop.use_imm)
  );

  reg_extract i_reg (
    .insn_q (insn_q),
    .opcode (opcode),
    .src1   (uop.src1),
    .src2   (uop.src2),
    .dst    (uop.dst)
  );

  uop_classify i_cls (
    .insn_q    (insn_q),
    .opcode    (opcode),
    .alu_op    (uop.alu_op),
    .fu_id     (uop.fu_id),
    .cond      (uop.cond),
    .set_nzcv  (uop.set_nzcv),
    .uses_nzcv (uop.uses_nzcv),
    .illegal   (uop.illegal)
  );

endmodule

// File: tb_vectors.svh
// Columns: test name, instruction word, expected micro-op built by uop_of from
// flags {illegal, set_nzcv, uses_nzcv, use_imm, fu_ls}, imm, src1, src2, dst, ALU op, cond.
add_vec("ldur", 32'hF84A5067, uop_of(5'b00011, 'hA5, 3, 0, 7, ALU_OP_PLUS, COND_EQ));
add_vec("stur", 32'hF8010049, uop_of(5'b00011, 'h10, 2, 9, 0, ALU_OP_PLUS, COND_EQ));
add_vec("ldp", 32'hA8C00022, uop_of(5'b00011, 'h0, 1, 0, 2, ALU_OP_PLUS, COND_EQ));
add_vec("stp", 32'hA9000085, uop_of(5'b00011, 'h0, 4, 0, 0, ALU_OP_PLUS, COND_EQ));
add_vec("movz", 32'hD2824683, uop_of(5'b00010, 'h1234, 0, 0, 3, ALU_OP_MOV, COND_EQ));
add_vec("movk", 32'hF297DDE1, uop_of(5'b00010, 'hBEEF, 0, 0, 1, ALU_OP_MOV, COND_EQ));
add_vec("adr", 32'h30000045, uop_of(5'b00010, 'h0, 0, 0, 5, ALU_OP_PLUS, COND_EQ));
add_vec("adrp", 32'hD0000064, uop_of(5'b00010, 'hE000, 0, 0, 4, ALU_OP_PLUS, COND_EQ));
add_vec("add", 32'h91048CC8, uop_of(5'b00010, 'h123, 6, 0, 8, ALU_OP_PLUS, COND_EQ));
add_vec("sub", 32'hD13FFFE0, uop_of(5'b00010, 'hFFF, 31, 0, 0, ALU_OP_MINUS, COND_EQ));
add_vec("adds", 32'hAB020023, uop_of(5'b01000, 'h0, 1, 2, 3, ALU_OP_PLUS, COND_EQ));
add_vec("subs", 32'hEB0400A6, uop_of(5'b01000, 'h0, 5, 4, 6, ALU_OP_MINUS, COND_EQ));
add_vec("ands", 32'hEA070109, uop_of(5'b01000, 'h0, 8, 7, 9, ALU_OP_AND, COND_EQ));
add_vec("and", 32'h92000441, uop_of(5'b00010, 'h0, 2, 0, 1, ALU_OP_AND, COND_EQ));
add_vec("orr", 32'hAA0A016C, uop_of(5'b00000, 'h0, 11, 10, 12, ALU_OP_OR, COND_EQ));
add_vec("orn", 32'hAA210043, uop_of(5'b00000, 'h0, 2, 1, 3, ALU_OP_ORN, COND_EQ));
add_vec("eor", 32'hCA0D01CF, uop_of(5'b00000, 'h0, 14, 13, 15, ALU_OP_EOR, COND_EQ));
add_vec("ubfm", 32'hD344FC41, uop_of(5'b00010, 'h13F, 2, 0, 1, ALU_OP_UBFM, COND_EQ));
add_vec("sbfm", 32'h93401C64, uop_of(5'b00010, 'h7, 3, 0, 4, ALU_OP_SBFM, COND_EQ));
add_vec("csel", 32'h9A85B0C7, uop_of(5'b00100, 'h0, 6, 5, 7, ALU_OP_CSEL, COND_LT));
add_vec("csinc", 32'h9A810443, uop_of(5'b00100, 'h0, 2, 1, 3, ALU_OP_CSINC, COND_EQ));
add_vec("csinv", 32'hDA88112A, uop_of(5'b00100, 'h0, 9, 8, 10, ALU_OP_CSINV, COND_NE));
add_vec("csneg", 32'hDA9FC401, uop_of(5'b00100, 'h0, 0, 31, 1, ALU_OP_CSNEG, COND_GT));
add_vec("b", 32'h14000010, uop_of(5'b00010, 'h0, 0, 0, 0, ALU_OP_PLUS, COND_EQ));
add_vec("b_cond", 32'h5400004A, uop_of(5'b00110, 'h0, 0, 0, 0, ALU_OP_PLUS, COND_GE));
add_vec("bl", 32'h94000020, uop_of(5'b00010, 'h0, 0, 0, 30, ALU_OP_PLUS, COND_EQ));
add_vec("blr", 32'hD63F0100, uop_of(5'b00010, 'h0, 8, 0, 30, ALU_OP_PLUS, COND_EQ));
add_vec("br", 32'hD61F0220, uop_of(5'b00010, 'h0, 17, 0, 0, ALU_OP_PLUS, COND_EQ));
add_vec("ret", 32'hD65F03C0, uop_of(5'b00000, 'h0, 30, 0, 0, ALU_OP_PLUS, COND_EQ));
add_vec("cbz", 32'hB4000065, uop_of(5'b00000, 'h0, 5, 0, 0, ALU_OP_PLUS, COND_EQ));
add_vec("cbnz", 32'hB5000043, uop_of(5'b00000, 'h0, 3, 0, 0, ALU_OP_PLUS, COND_EQ));
add_vec("nop", 32'hD503201F, uop_of(5'b00000, 'h0, 0, 0, 0, ALU_OP_PLUS, COND_EQ));
add_vec("hlt", 32'hD4400000, uop_of(5'b00000, 'h0, 0, 0, 0, ALU_OP_PLUS, COND_EQ));
// Unsupported encodings decode as illegal.
add_vec("add_w", 32'h11000C41, uop_of(5'b10000, 'h0, 0, 0, 0, ALU_OP_PLUS, COND_EQ));
add_vec("svc", 32'hD4000001, uop_of(5'b10000, 'h0, 0, 0, 0, ALU_OP_PLUS, COND_EQ));

// File: tb_dispatch.sv
`timescale 1ns/100ps

module tb_dispatch import dispatch_pkg::*; ();

  logic          in_clk;
  logic          rst_n;
  logic          in_stall;
  logic          in_fetch_done;
  logic [31:0]   in_fetch_insn;
  logic          done;
  dispatch_uop_t uop;

  string         names[$];
  logic [31:0]   insns[$];
  dispatch_uop_t expects[$];
  logic [15:0]   lfsr;
  int            cycles;
  int            cycle_limit;
  int            n_pass;
  int            n_fail;
  int            test_errors;

  dispatch_stage i_dut (
    .in_clk        (in_clk),
    .rst_n         (rst_n),
    .in_stall      (in_stall),
    .in_fetch_done (in_fetch_done),
    .in_fetch_insn (in_fetch_insn),
    .done          (done),
    .uop           (uop)
  );

  always #20 in_clk = ~in_clk;

  always @(posedge in_clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the run did not end within %0d cycles", cycle_limit);
      $display("sim failed");
      $finish;
    end
  end

  // Galois LFSR with taps 16, 14, 13 and 11.
  function automatic logic next_bit();
    logic b;
    b = lfsr[0];
    lfsr = {1'b0, lfsr[15:1]} ^ (b ? 16'hB400 : 16'h0000);
    return b;
  endfunction

  // Word of another row whose expected micro-op differs from this row's.
  function automatic logic [31:0] differing_insn(int row);
    for (int j = 0; j < names.size(); j++) begin
      if (expects[j] !== expects[row]) begin
        return insns[j];
      end
    end
    return ~insns[row];
  endfunction

  // Flags are {illegal, set_nzcv, uses_nzcv, use_imm, fu_ls}.
  function automatic dispatch_uop_t uop_of(logic [4:0] flags, logic [63:0] imm, int src1,
                                           int src2, int dst, alu_op_t alu_op, cond_t cond);
    dispatch_uop_t u;
    u.illegal   = flags[4];
    u.set_nzcv  = flags[3];
    u.uses_nzcv = flags[2];
    u.use_imm   = flags[1];
    u.fu_id     = fu_t'(flags[0]);
    u.imm       = imm;
    u.src1      = 5'(src1);
    u.src2      = 5'(src2);
    u.dst       = 5'(dst);
    u.alu_op    = alu_op;
    u.cond      = cond;
    return u;
  endfunction

  task automatic add_vec(string name, logic [31:0] insn, dispatch_uop_t exp);
    names.push_back(name);
    insns.push_back(insn);
    expects.push_back(exp);
  endtask

  task automatic load_vectors();
    `include "tb_vectors.svh"
  endtask

  task automatic check_done(string name, logic exp);
    if (done !== exp) begin
      $display("MISMATCH %s done expected %b actual %b", name, exp, done);
      test_errors++;
    end
  endtask

  task automatic check_uop(string name, dispatch_uop_t exp);
    if (uop !== exp) begin
      $display("MISMATCH %s uop expected %h actual %h", name, exp, uop);
      test_errors++;
    end
  endtask

  task automatic finish_test(string name);
    if (test_errors == 0) begin
      n_pass++;
      $display("PASS %s", name);
    end else begin
      n_fail++;
      $display("FAIL %s", name);
    end
    test_errors = 0;
  endtask

  initial begin
    logic [1:0] idle;
    in_clk        = 1'b0;
    rst_n         = 1'b0;
    in_stall      = 1'b0;
    in_fetch_done = 1'b0;
    in_fetch_insn = '0;
    lfsr          = 16'd62979;
    cycles        = 0;
    n_pass        = 0;
    n_fail        = 0;
    test_errors   = 0;
    load_vectors();
    cycle_limit = names.size() * 8 + 20;
    repeat (2) @(negedge in_clk);
    rst_n = 1'b1;
    // Cleared register holds the zero word, which decodes as illegal.
    check_done("reset", 1'b0);
    check_uop("reset", uop_of(5'b10000, 'h0, 0, 0, 0, ALU_OP_PLUS, COND_EQ));
    finish_test("reset");
    for (int i = 0; i < names.size(); i++) begin
      in_fetch_done = 1'b1;
      in_fetch_insn = insns[i];
      @(negedge in_clk);
      in_fetch_done = 1'b0;
      check_done(names[i], 1'b1);
      check_uop(names[i], expects[i]);
      if (next_bit()) begin
        // A strobe offered under stall must be dropped.
        in_stall      = 1'b1;
        in_fetch_done = 1'b1;
        in_fetch_insn = differing_insn(i);
        @(negedge in_clk);
        in_fetch_done = 1'b0;
        @(negedge in_clk);
        check_done(names[i], 1'b1);
        check_uop(names[i], expects[i]);
        in_stall = 1'b0;
      end
      idle = {next_bit(), next_bit()};
      if (idle != 2'd0) begin
        @(negedge in_clk);
        check_done(names[i], 1'b0);
        check_uop(names[i], expects[i]);
        repeat (idle - 2'd1) @(negedge in_clk);
      end
      finish_test(names[i]);
    end
    $display("Tests passed %0d failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+.
dispatch_pkg.sv
dispatch_ctrl.sv
imm_extract.sv
reg_extract.sv
uop_classify.sv
dispatch_stage.sv
tb_dispatch.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the dispatch stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -f verilog.f --top-module tb_dispatch -o tb_dispatch
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_dispatch)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
